// File: tests/uart_trace.txt
# name dip cmd stop reply gpio gpio_dir (hex, reply "none" when no answer)
# stop 0 sends the command with a low stop bit, i.e. a framing error
echo_25 3 25 1 25 000 000
echo_3f 3 3F 1 3F 000 000
echo_00 5 00 1 00 000 000
wr_led_lo 5 4A 1 0A 0A0 000
wr_led_hi 5 55 1 5A 5A0 000
wr_dir_lo 6 63 1 03 5A0 030
wr_dir_hi 6 7C 1 C3 5A0 C30
rd_dip_9 9 87 1 09 5A0 C30
rd_led 9 90 1 5A 5A0 C30
rd_dir 9 A0 1 C3 5A0 C30
rd_bank3_err 9 B0 1 EE 5A0 C30
op3_err_c5 2 C5 1 EE 5A0 C30
op3_err_ff 2 FF 1 EE 5A0 C30
frame_err_wr 2 4F 0 none 5A0 C30
rd_led_after_ferr 2 90 1 5A 5A0 C30
wr_led_lo_1 2 41 1 51 510 C30
rd_dip_0 0 8E 1 00 510 C30
frame_err_echo 0 12 0 none 510 C30
echo_1d 0 1D 1 1D 510 C30
wr_dir_hi_0 0 70 1 03 510 030
rd_dir_2 0 A9 1 03 510 030
rd_dip_f F 80 1 0F 510 030

// File: project.f
source/soc_pkg.sv
source/pad_ring.sv
source/prci_reset.sv
source/uart_rx.sv
source/cmd_decoder.sv
source/gpio_ctrl.sv
source/uart_tx.sv
source/asic_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench and DUT with Verilator, run it, then scan the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --top-module tb_top -Mdir obj_dir -o tb_sim -f project.f \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  || { echo "Verilator build or simulation run did not complete"; exit 1; }
cat sim.log
grep -q "sim failed" sim.log && { echo "RESULT: FAIL"; exit 1; } || { echo "RESULT: PASS"; exit 0; }

// File: tests/tb_top.sv
// ================================================
// Testbench top for the UART1 GPIO subsystem
// Reads the command trace, drives UART frames and
// DIP pins into dut0, and ends the run
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tb_top;

  import soc_pkg::*;

  localparam int unsigned SEED = 32'hd0bd;
  localparam int CLK_HALF = 20;
  localparam int DRV_DLY = 2;
  localparam int RESET_CYCLES = 10;

  logic              clk;
  logic              reset;
  logic [GPIO_W-1:0] gpio_in;
  logic [GPIO_W-1:0] gpio_out;
  logic [GPIO_W-1:0] gpio_dir;
  logic              uart_rd;
  logic              uart_td;

  // Current test as seen by the checker
  logic              start;
  logic              idle_check;
  logic [191:0]      cur_name;
  logic              cur_rep_en;
  logic [7:0]        cur_rep;
  logic [GPIO_W-1:0] cur_gpio;
  logic [GPIO_W-1:0] cur_dir;
  int                done_cnt;
  int                pass_cnt;
  int                fail_cnt;

  // Trace columns with one entry per command
  logic [191:0]      t_name[$];
  logic [3:0]        t_dip[$];
  logic [7:0]        t_cmd[$];
  logic              t_stop[$];
  logic              t_rep_en[$];
  logic [7:0]        t_rep[$];
  logic [GPIO_W-1:0] t_gpio[$];
  logic [GPIO_W-1:0] t_dir[$];

  int                limit;
  int                cycle_cnt;

  asic_top dut0 (
    .i_clk     (clk),
    .i_reset   (reset),
    .i_gpio    (gpio_in),
    .o_gpio    (gpio_out),
    .o_gpio_dir(gpio_dir),
    .i_uart1_rd(uart_rd),
    .o_uart1_td(uart_td)
  );

  tb_checker chk0 (
    .i_clk       (clk),
    .i_start     (start),
    .i_idle_check(idle_check),
    .i_name      (cur_name),
    .i_exp_valid (cur_rep_en),
    .i_exp_reply (cur_rep),
    .i_exp_gpio  (cur_gpio),
    .i_exp_dir   (cur_dir),
    .i_td        (uart_td),
    .i_gpio      (gpio_out),
    .i_gpio_dir  (gpio_dir),
    .o_done_cnt  (done_cnt),
    .o_pass_cnt  (pass_cnt),
    .o_fail_cnt  (fail_cnt)
  );

  initial clk = 1'b0;
  always #CLK_HALF clk = ~clk;

  // Inputs change just after the rising edge
  task automatic next_cycle();
    @(posedge clk);
    #DRV_DLY;
  endtask

  // 8N1 frame sent LSB first with the stop level taken from the trace
  task automatic send_uart_byte(input logic [7:0] data, input logic stop_bit);
    int b;
    uart_rd = 1'b0;
    repeat (CLKS_PER_BIT) next_cycle();
    for (b = 0; b < 8; b++) begin
      uart_rd = data[b];
      repeat (CLKS_PER_BIT) next_cycle();
    end
    uart_rd = stop_bit;
    repeat (CLKS_PER_BIT) next_cycle();
    // Line returns to idle so a low stop bit is not stretched
    uart_rd = 1'b1;
  endtask

  task automatic wait_done(input int count);
    while (done_cnt < count) next_cycle();
  endtask

  // Lines that start with # are skipped and a none reply means no answer
  task automatic load_trace(output int ok);
    int           fd;
    int           rc;
    int           stp_i;
    string        line;
    string        rep_s;
    logic [191:0] nm;
    logic [3:0]   dip;
    logic [7:0]   cmd;
    logic [7:0]   rep;
    logic [11:0]  gp;
    logic [11:0]  dr;
    ok = 0;
    fd = $fopen("tests/uart_trace.txt", "r");
    if (fd != 0) begin
      while (!$feof(fd)) begin
        line = "";
        rc = $fgets(line, fd);
        if (rc == 0 || line.len() < 2 || line.getc(0) == "#") continue;
        rc = $sscanf(line, "%s %h %h %d %s %h %h", nm, dip, cmd, stp_i, rep_s, gp, dr);
        if (rc != 7) begin
          $display("trace line not understood: %s", line);
          continue;
        end
        rep = 8'h00;
        if (rep_s != "none") rc = $sscanf(rep_s, "%h", rep);
        t_name.push_back(nm);
        t_dip.push_back(dip);
        t_cmd.push_back(cmd);
        t_stop.push_back(stp_i != 0);
        t_rep_en.push_back(rep_s != "none");
        t_rep.push_back(rep);
        t_gpio.push_back(gp);
        t_dir.push_back(dr);
      end
      $fclose(fd);
      ok = (t_cmd.size() > 0) ? 1 : 0;
    end
  endtask

  initial begin
    int ok;
    int i;
    int gap;
    void'($urandom(SEED));
    reset = 1'b1;
    uart_rd = 1'b1;
    gpio_in = '0;
    start = 1'b0;
    idle_check = 1'b0;
    cur_name = '0;
    cur_rep_en = 1'b0;
    cur_rep = '0;
    cur_gpio = '0;
    cur_dir = '0;
    load_trace(ok);
    if (ok == 0) begin
      $display("could not read any command from tests/uart_trace.txt");
      $display("sim failed");
    end else begin
      // Room for frame, reply and gap per command plus the reset phase
      limit = t_cmd.size() * 30 * CLKS_PER_BIT + 200;
      repeat (RESET_CYCLES) next_cycle();
      reset = 1'b0;
      // System reset is stretched by the PRCI block
      repeat (RESET_HOLD + 4) next_cycle();
      idle_check = 1'b1;
      next_cycle();
      idle_check = 1'b0;
      wait_done(1);
      for (i = 0; i < t_cmd.size(); i++) begin
        // LED half of i_gpio is unused by the DUT and gets random noise
        gpio_in = {8'($urandom), t_dip[i]};
        cur_name = t_name[i];
        cur_rep_en = t_rep_en[i];
        cur_rep = t_rep[i];
        cur_gpio = t_gpio[i];
        cur_dir = t_dir[i];
        start = 1'b1;
        next_cycle();
        start = 1'b0;
        send_uart_byte(t_cmd[i], t_stop[i]);
        wait_done(i + 2);
        gap = int'($urandom % 8) + 2;
        repeat (gap) next_cycle();
      end
      $display("results: %0d passed, %0d failed", pass_cnt, fail_cnt);
      if (fail_cnt == 0) begin
        $display("sim passed");
      end else begin
        $display("sim failed");
      end
    end
    $finish;
  end

  // Cycle budget armed once the trace length is known
  initial begin
    cycle_cnt = 0;
    wait (limit != 0);
    while (cycle_cnt < limit) begin
      @(posedge clk);
      cycle_cnt++;
    end
    $display("timeout: run did not complete within %0d clock cycles", limit);
    $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

// File: tests/tb_checker.sv
// ================================================
// Testbench checker
// Decodes replies on the UART1 transmit line and
// compares them and the GPIO outputs per test
// ================================================
`timescale 1ns/1ps
`default_nettype none

module tb_checker (
  input  logic                       i_clk,
  input  logic                       i_start,
  input  logic                       i_idle_check,
  // Test name of up to 24 ASCII characters
  input  logic [191:0]               i_name,
  input  logic                       i_exp_valid,
  input  logic [7:0]                 i_exp_reply,
  input  logic [soc_pkg::GPIO_W-1:0] i_exp_gpio,
  input  logic [soc_pkg::GPIO_W-1:0] i_exp_dir,
  // DUT outputs
  input  logic                       i_td,
  input  logic [soc_pkg::GPIO_W-1:0] i_gpio,
  input  logic [soc_pkg::GPIO_W-1:0] i_gpio_dir,
  output int                         o_done_cnt,
  output int                         o_pass_cnt,
  output int                         o_fail_cnt
);

  import soc_pkg::*;

  // Frame in plus pipeline latency with margin
  localparam int REPLY_WINDOW = 14 * CLKS_PER_BIT;

  logic busy;
  logic armed;
  logic td_prev;
  int   test_fail;
  int   stray_cnt;

  assign o_fail_cnt = test_fail + stray_cnt;

  task automatic compare_value(input string sig, input logic [GPIO_W-1:0] exp_v,
                               input logic [GPIO_W-1:0] act_v, inout int errs);
    if (exp_v !== act_v) begin
      $display("ERROR t=%0t %s expected 0x%03h actual 0x%03h", $time, sig, exp_v, act_v);
      errs++;
    end
  endtask

  task automatic report_test(input string nm, input int errs);
    if (errs == 0) begin
      o_pass_cnt++;
      $display("PASS %s", nm);
    end else begin
      test_fail++;
      $display("FAIL %s with %0d mismatches", nm, errs);
    end
    o_done_cnt++;
  endtask

  // Line idle and registers cleared after reset
  task automatic check_idle();
    int errs;
    errs = 0;
    compare_value("o_uart1_td", {{(GPIO_W-1){1'b0}}, 1'b1}, {{(GPIO_W-1){1'b0}}, i_td}, errs);
    compare_value("o_gpio", '0, i_gpio, errs);
    compare_value("o_gpio_dir", '0, i_gpio_dir, errs);
    report_test("reset_idle", errs);
  endtask

  task automatic run_test();
    int         waited;
    int         b;
    int         errs;
    logic       seen;
    logic [7:0] got;
    busy = 1'b1;
    errs = 0;
    waited = 0;
    seen = 1'b0;
    got = '0;
    // Start bit is the first low level seen at a falling edge
    while (!seen && waited < REPLY_WINDOW) begin
      @(negedge i_clk);
      waited++;
      seen = (i_td === 1'b0);
    end
    if (i_exp_valid && !seen) begin
      $display("%0s: no reply start bit within %0d cycles", i_name, REPLY_WINDOW);
      errs++;
    end else if (i_exp_valid) begin
      // Move to mid start bit and then sample once per bit period
      repeat (CLKS_PER_BIT / 2) @(negedge i_clk);
      if (i_td !== 1'b0) begin
        $display("%0s: start bit ended before its midpoint", i_name);
        errs++;
      end
      for (b = 0; b < 8; b++) begin
        repeat (CLKS_PER_BIT) @(negedge i_clk);
        got[b] = i_td;
      end
      repeat (CLKS_PER_BIT) @(negedge i_clk);
      if (i_td !== 1'b1) begin
        $display("%0s: reply stop bit was low", i_name);
        errs++;
      end
      compare_value("o_uart1_td reply", {4'h0, i_exp_reply}, {4'h0, got}, errs);
    end else if (seen) begin
      $display("%0s: start bit seen but no reply was expected", i_name);
      errs++;
      // Let the stray frame finish
      repeat (10 * CLKS_PER_BIT) @(negedge i_clk);
    end
    compare_value("o_gpio", i_exp_gpio, i_gpio, errs);
    compare_value("o_gpio_dir", i_exp_dir, i_gpio_dir, errs);
    report_test($sformatf("%0s", i_name), errs);
    busy = 1'b0;
  endtask

  // Tests run one at a time and sample on the falling edge
  initial begin
    busy = 1'b0;
    armed = 1'b0;
    o_done_cnt = 0;
    o_pass_cnt = 0;
    test_fail = 0;
    forever begin
      @(negedge i_clk);
      if (i_idle_check) begin
        check_idle();
        armed = 1'b1;
      end else if (i_start) begin
        run_test();
      end
    end
  end

  // Any start bit outside a test is a stray reply
  initial begin
    td_prev = 1'b1;
    stray_cnt = 0;
    forever begin
      @(negedge i_clk);
      if (armed && !busy && td_prev && !i_td) begin
        $display("t=%0t start bit on o_uart1_td while no command was pending", $time);
        stray_cnt++;
      end
      td_prev = i_td;
    end
  end

endmodule

`default_nettype wire

// File: source/asic_top.sv
// ================================================
// Chip top
// UART1 command port driving the LED and DIP
// switch GPIO block
// ================================================
`timescale 1ns/1ps
`default_nettype none

module asic_top (
  input  logic                       i_clk,
  // External reset, active high
  input  logic                       i_reset,
  // GPIO: [11:4] LEDs, [3:0] DIP switches
  input  logic [soc_pkg::GPIO_W-1:0] i_gpio,
  output logic [soc_pkg::GPIO_W-1:0] o_gpio,
  output logic [soc_pkg::GPIO_W-1:0] o_gpio_dir,
  // UART1
  input  logic                       i_uart1_rd,
  output logic                       o_uart1_td
);

  import soc_pkg::*;

  logic             w_sys_reset;
  logic             ib_uart1_rd;
  logic [DIP_W-1:0] ib_dip;

  // Receiver to decoder
  logic             w_byte_valid;
  logic [7:0]       w_byte;
  logic             w_frame_err;

  // Decoder to GPIO stage
  logic             w_echo;
  logic             w_wr;
  logic             w_rd;
  logic             w_err;
  logic [1:0]       w_bank;
  logic [3:0]       w_value;
  logic [7:0]       w_raw;

  // GPIO stage to transmitter
  logic             w_reply_valid;
  logic [7:0]       w_reply;

  // Only the DIP pins are read back
  pad_ring pad0 (
    .i_clk         (i_clk),
    .i_reset       (w_sys_reset),
    .i_uart_rd     (i_uart1_rd),
    .i_dip         (i_gpio[DIP_W-1:0]),
    .o_uart_rd_sync(ib_uart1_rd),
    .o_dip_sync    (ib_dip)
  );

  prci_reset prci0 (
    .i_clk      (i_clk),
    .i_reset    (i_reset),
    .o_sys_reset(w_sys_reset)
  );

  uart_rx rx0 (
    .i_clk       (i_clk),
    .i_reset     (w_sys_reset),
    .i_rd        (ib_uart1_rd),
    .o_byte_valid(w_byte_valid),
    .o_byte      (w_byte),
    .o_frame_err (w_frame_err)
  );

  cmd_decoder dec0 (
    .i_clk       (i_clk),
    .i_reset     (w_sys_reset),
    .i_byte_valid(w_byte_valid),
    .i_byte      (w_byte),
    .i_frame_err (w_frame_err),
    .o_echo      (w_echo),
    .o_wr        (w_wr),
    .o_rd        (w_rd),
    .o_err       (w_err),
    .o_bank      (w_bank),
    .o_value     (w_value),
    .o_raw       (w_raw)
  );

  gpio_ctrl gpio0 (
    .i_clk        (i_clk),
    .i_reset      (w_sys_reset),
    .i_echo       (w_echo),
    .i_wr         (w_wr),
    .i_rd         (w_rd),
    .i_err        (w_err),
    .i_bank       (w_bank),
    .i_value      (w_value),
    .i_raw        (w_raw),
    .i_dip        (ib_dip),
    .o_gpio       (o_gpio),
    .o_gpio_dir   (o_gpio_dir),
    .o_reply_valid(w_reply_valid),
    .o_reply      (w_reply)
  );

  uart_tx tx0 (
    .i_clk  (i_clk),
    .i_reset(w_sys_reset),
    .i_valid(w_reply_valid),
    .i_data (w_reply),
    .o_td   (o_uart1_td)
  );

endmodule

`default_nettype wire

// File: source/uart_tx.sv
// ================================================
// UART 8N1 transmitter
// Sends the reply byte LSB first framed by one
// start and one stop bit
// ================================================
`timescale 1ns/1ps
`default_nettype none

module uart_tx (
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_valid,
  input  logic [7:0] i_data,
  output logic       o_td
);

  import soc_pkg::*;

  logic             busy;
  logic [TMR_W-1:0] tmr;
  // Bit slot now on the line, 0 is start and 9 is stop
  logic [3:0]       bit_cnt;
  // Data bits still to send followed by the stop bit
  logic [8:0]       shift;
  logic             load;
  logic             bit_end;

  // New bytes are ignored while a frame is in flight
  assign load    = i_valid && !busy;
  assign bit_end = busy && (tmr == TMR_LAST);

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      busy    <= 1'b0;
      tmr     <= '0;
      bit_cnt <= '0;
      o_td    <= 1'b1;
    end else if (load) begin
      // Start bit goes out the cycle after the strobe
      busy    <= 1'b1;
      tmr     <= '0;
      bit_cnt <= '0;
      o_td    <= 1'b0;
    end else if (bit_end) begin
      tmr <= '0;
      if (bit_cnt == 4'd9) begin
        // Stop bit done, line stays high
        busy <= 1'b0;
      end else begin
        bit_cnt <= bit_cnt + 1'b1;
        o_td    <= shift[0];
      end
    end else if (busy) begin
      tmr <= tmr + 1'b1;
    end
  end

  always_ff @(posedge i_clk) begin
    if (load) begin
      shift <= {1'b1, i_data};
    end else if (bit_end) begin
      shift <= {1'b1, shift[8:1]};
    end
  end

endmodule

`default_nettype wire

// File: source/gpio_ctrl.sv
// ================================================
// GPIO register stage
// LED and direction registers with nibble writes,
// plus reply byte selection
// ================================================
`timescale 1ns/1ps
`default_nettype none

module gpio_ctrl (
  input  logic                       i_clk,
  input  logic                       i_reset,
  input  logic                       i_echo,
  input  logic                       i_wr,
  input  logic                       i_rd,
  input  logic                       i_err,
  input  logic [1:0]                 i_bank,
  input  logic [3:0]                 i_value,
  input  logic [7:0]                 i_raw,
  input  logic [soc_pkg::DIP_W-1:0]  i_dip,
  output logic [soc_pkg::GPIO_W-1:0] o_gpio,
  output logic [soc_pkg::GPIO_W-1:0] o_gpio_dir,
  output logic                       o_reply_valid,
  output logic [7:0]                 o_reply
);

  import soc_pkg::*;

  logic [LED_W-1:0] led_reg;
  logic [LED_W-1:0] dir_reg;
  logic [LED_W-1:0] led_next;
  logic [LED_W-1:0] dir_next;
  logic [7:0]       reply_next;

  // Nibble write by bank
  always_comb begin
    led_next = led_reg;
    dir_next = dir_reg;
    if (i_wr) begin
      case (i_bank)
        BANK_LED_LO: led_next[3:0] = i_value;
        BANK_LED_HI: led_next[7:4] = i_value;
        BANK_DIR_LO: dir_next[3:0] = i_value;
        default:     dir_next[7:4] = i_value;
      endcase
    end
  end

  // Reply selection, a write returns the updated register
  always_comb begin
    reply_next = REPLY_ERR;
    if (i_echo) begin
      reply_next = i_raw;
    end else if (i_wr) begin
      reply_next = i_bank[1] ? dir_next : led_next;
    end else if (i_rd) begin
      case (i_bank)
        2'd0:    reply_next = {{(LED_W - DIP_W){1'b0}}, i_dip};
        2'd1:    reply_next = led_reg;
        default: reply_next = dir_reg;
      endcase
    end
  end

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      led_reg       <= '0;
      dir_reg       <= '0;
      o_reply_valid <= 1'b0;
    end else begin
      led_reg       <= led_next;
      dir_reg       <= dir_next;
      o_reply_valid <= i_echo | i_wr | i_rd | i_err;
    end
  end

  always_ff @(posedge i_clk) begin
    o_reply <= reply_next;
  end

  // DIP pins stay inputs and drive nothing
  assign o_gpio     = {led_reg, {DIP_W{1'b0}}};
  assign o_gpio_dir = {dir_reg, {DIP_W{1'b0}}};

endmodule

`default_nettype wire

// File: source/cmd_decoder.sv
// ================================================
// Command decoder
// Splits each received byte into one-hot command
// strobes plus bank, value and raw byte
// ================================================
`timescale 1ns/1ps
`default_nettype none

module cmd_decoder (
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_byte_valid,
  input  logic [7:0] i_byte,
  input  logic       i_frame_err,
  output logic       o_echo,
  output logic       o_wr,
  output logic       o_rd,
  output logic       o_err,
  output logic [1:0] o_bank,
  output logic [3:0] o_value,
  output logic [7:0] o_raw
);

  import soc_pkg::*;

  cmd_byte_u cmd;
  logic      accept;

  assign cmd.raw = i_byte;
  // Bytes with a bad stop bit vanish here
  assign accept = i_byte_valid && !i_frame_err;

  // Strobes, at most one high per cycle
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      o_echo <= 1'b0;
      o_wr   <= 1'b0;
      o_rd   <= 1'b0;
      o_err  <= 1'b0;
    end else begin
      o_echo <= accept && (cmd.fields.op == OP_ECHO);
      o_wr   <= accept && (cmd.fields.op == OP_WRITE);
      // Read space has only DIP, LED and DIR banks
      o_rd   <= accept && (cmd.fields.op == OP_READ) &&
                (cmd.fields.bank != BANK_DIR_HI);
      o_err  <= accept && ((cmd.fields.op == OP_RSVD) ||
                ((cmd.fields.op == OP_READ) && (cmd.fields.bank == BANK_DIR_HI)));
    end
  end

  // Payload travels alongside the strobe
  always_ff @(posedge i_clk) begin
    if (accept) begin
      o_bank  <= cmd.fields.bank;
      o_value <= cmd.fields.value;
      o_raw   <= cmd.raw;
    end
  end

endmodule

`default_nettype wire

// File: source/uart_rx.sv
// ================================================
// UART 8N1 receiver
// Samples each bit at its midpoint and returns a
// byte strobe with a framing error flag
// ================================================
`timescale 1ns/1ps
`default_nettype none

module uart_rx (
  input  logic       i_clk,
  input  logic       i_reset,
  input  logic       i_rd,
  output logic       o_byte_valid,
  output logic [7:0] o_byte,
  output logic       o_frame_err
);

  import soc_pkg::*;

  logic [1:0]       state;
  logic [TMR_W-1:0] tmr;
  logic [2:0]       bit_idx;
  // Previous line level for edge detection
  logic             rd_q;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      state        <= RX_IDLE;
      tmr          <= '0;
      bit_idx      <= '0;
      rd_q         <= 1'b1;
      o_byte_valid <= 1'b0;
      o_frame_err  <= 1'b0;
    end else begin
      rd_q         <= i_rd;
      o_byte_valid <= 1'b0;
      case (state)
        RX_IDLE: begin
          // Falling edge only, a line held low after a
          // bad stop bit does not restart the receiver
          if (rd_q && !i_rd) begin
            state <= RX_START;
            tmr   <= '0;
          end
        end
        RX_START: begin
          if (tmr == TMR_HALF) begin
            tmr     <= '0;
            bit_idx <= '0;
            // Glitch shorter than half a bit is a false start
            state   <= i_rd ? RX_IDLE : RX_DATA;
          end else begin
            tmr <= tmr + 1'b1;
          end
        end
        RX_DATA: begin
          if (tmr == TMR_LAST) begin
            tmr <= '0;
            if (bit_idx == 3'd7) begin
              state <= RX_STOP;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end else begin
            tmr <= tmr + 1'b1;
          end
        end
        default: begin
          // Stop bit midpoint, flag it if the line is low
          if (tmr == TMR_LAST) begin
            o_byte_valid <= 1'b1;
            o_frame_err  <= ~i_rd;
            state        <= RX_IDLE;
          end else begin
            tmr <= tmr + 1'b1;
          end
        end
      endcase
    end
  end

  // Data shifts in LSB first, holds until next byte
  always_ff @(posedge i_clk) begin
    if (state == RX_DATA && tmr == TMR_LAST) begin
      o_byte <= {i_rd, o_byte[7:1]};
    end
  end

endmodule

`default_nettype wire

// File: source/prci_reset.sv
// ================================================
// Reset controller
// Holds the system reset for a fixed number of
// cycles after the external reset is released
// ================================================
`timescale 1ns/1ps
`default_nettype none

module prci_reset (
  input  logic i_clk,
  input  logic i_reset,
  output logic o_sys_reset
);

  import soc_pkg::*;

  // Cycles left before the system leaves reset
  logic [RST_CNT_W-1:0] hold_cnt;

  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      // Reload while the external reset is asserted
      hold_cnt    <= RST_CNT_LOAD;
      o_sys_reset <= 1'b1;
    end else if (hold_cnt != '0) begin
      hold_cnt    <= hold_cnt - 1'b1;
      o_sys_reset <= 1'b1;
    end else begin
      // Single registered release edge for all stages
      o_sys_reset <= 1'b0;
    end
  end

endmodule

`default_nettype wire

// File: source/pad_ring.sv
// ================================================
// Input pad stage
// Two-flop synchronizers for the UART receive
// line and the DIP switch pins
// ================================================
`timescale 1ns/1ps
`default_nettype none

module pad_ring (
  input  logic                      i_clk,
  input  logic                      i_reset,
  // Asynchronous pins from the board
  input  logic                      i_uart_rd,
  input  logic [soc_pkg::DIP_W-1:0] i_dip,
  // Synchronized copies
  output logic                      o_uart_rd_sync,
  output logic [soc_pkg::DIP_W-1:0] o_dip_sync
);

  import soc_pkg::*;

  // First stage flops, may go metastable
  logic             rd_meta;
  logic [DIP_W-1:0] dip_meta;

  // Receive line chain, idles high
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      rd_meta        <= 1'b1;
      o_uart_rd_sync <= 1'b1;
    end else begin
      rd_meta        <= i_uart_rd;
      o_uart_rd_sync <= rd_meta;
    end
  end

  // DIP switch chain, cleared to all off
  always_ff @(posedge i_clk) begin
    if (i_reset) begin
      dip_meta   <= '0;
      o_dip_sync <= '0;
    end else begin
      dip_meta   <= i_dip;
      o_dip_sync <= dip_meta;
    end
  end

  // Switches are slow, so per-bit sync is enough
  // (no bus coherency needed across the 4 bits)

endmodule

`default_nettype wire

// File: source/soc_pkg.sv
// ================================================
// SoC shared definitions
// UART timing, GPIO widths, command codes and the
// command byte layout used across the subsystem
// ================================================
`default_nettype none

package soc_pkg;

  // UART bit timing, kept short for simulation
  localparam int CLKS_PER_BIT = 8;
  localparam int TMR_W = $clog2(CLKS_PER_BIT);
  localparam logic [TMR_W-1:0] TMR_LAST = TMR_W'(CLKS_PER_BIT - 1);
  localparam logic [TMR_W-1:0] TMR_HALF = TMR_W'(CLKS_PER_BIT / 2 - 1);

  // Receiver FSM state codes
  localparam logic [1:0] RX_IDLE = 2'd0;
  localparam logic [1:0] RX_START = 2'd1;
  localparam logic [1:0] RX_DATA = 2'd2;
  localparam logic [1:0] RX_STOP = 2'd3;

  // GPIO pins: [11:4] LEDs, [3:0] DIP switches
  localparam int GPIO_W = 12;
  localparam int LED_W = 8;
  localparam int DIP_W = 4;

  // Reset stretch after the external reset falls
  localparam int RESET_HOLD = 16;
  localparam int RST_CNT_W = $clog2(RESET_HOLD + 1);
  localparam logic [RST_CNT_W-1:0] RST_CNT_LOAD = RST_CNT_W'(RESET_HOLD);

  // Command opcodes
  localparam logic [1:0] OP_ECHO = 2'd0;
  localparam logic [1:0] OP_WRITE = 2'd1;
  localparam logic [1:0] OP_READ = 2'd2;
  localparam logic [1:0] OP_RSVD = 2'd3;

  // Register bank codes
  localparam logic [1:0] BANK_LED_LO = 2'd0;
  localparam logic [1:0] BANK_LED_HI = 2'd1;
  localparam logic [1:0] BANK_DIR_LO = 2'd2;
  localparam logic [1:0] BANK_DIR_HI = 2'd3;

  // Reply to any rejected command
  localparam logic [7:0] REPLY_ERR = 8'hEE;

  // One command byte, seen raw or split into fields
  typedef union packed {
    logic [7:0] raw;
    struct packed {
      logic [1:0] op;
      logic [1:0] bank;
      logic [3:0] value;
    } fields;
  } cmd_byte_u;

endpackage

`default_nettype wire
